// ==== verilog/rv_check_macros.svh ====
`ifndef RV_CHECK_MACROS_SVH
`define RV_CHECK_MACROS_SVH

// Data and address width
`define XLEN 32
`define NREGS 32
`define REG_AW 5

// ADDI x0, x0, 0 fills empty stages
`define NOP_INST 32'h0000_0013
`define PC_RESET 32'h0000_0200

// PD, ID, EX, MEM, WB
`define NSTAGES 5

`endif

// ==== verilog/rv_check_pkg.sv ====
`include "rv_check_macros.svh"

package rv_check_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One fetched word, viewed in every encoding format
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
        logic [31:0] raw;
    } inst_u;

    typedef struct packed {
        inst_u             inst;
        logic [`XLEN-1:0]  pc;
        logic              valid;  // Clear for a bubble
        logic              legal;
    } slot_t;

    typedef enum logic [2:0] {
        ERR_NONE       = 3'd0,
        ERR_DST        = 3'd1,
        ERR_VALUE      = 3'd2,
        ERR_ADDR       = 3'd3,
        ERR_BRANCH     = 3'd4,
        ERR_ILLEGAL_WE = 3'd5
    } err_code_e;

endpackage

// ==== verilog/retire_if.sv ====
`include "rv_check_macros.svh"

interface retire_if;
    import rv_check_pkg::*;

    slot_t            slot;     // Instruction in the WB slot
    logic             retire;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;

    modport follower (output slot, output retire);

    // Operand lookup for the retiring slot
    modport regs (input slot, input retire, output rs1_val, output rs2_val);

    modport exec (input slot, input retire, input rs1_val, input rs2_val);

endinterface

// ==== verilog/inst_legality.sv ====
module inst_legality (
    input  rv_check_pkg::inst_u inst_i,
    output logic                legal_o
);
    import rv_check_pkg::*;

    logic [9:0] funct10;  // {funct7, funct3}

    assign funct10 = {inst_i.r.funct7, inst_i.r.funct3};

    always_comb begin
        case (inst_i.r.opcode)
            OPC_LUI,
            OPC_AUIPC:  legal_o = 1'b1;
            OPC_JAL:    legal_o = !inst_i.j.imm10_1[0];  // Target offset multiple of 4
            OPC_JALR:   legal_o = (inst_i.i.funct3 == 3'b000) && (inst_i.i.imm[1:0] == 2'b00);
            OPC_BRANCH: begin
                legal_o = (inst_i.b.funct3 inside {3'b000, 3'b001, 3'b100,
                                                   3'b101, 3'b110, 3'b111})
                          && !inst_i.b.imm4_1[0];
            end
            OPC_LOAD:   legal_o = inst_i.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            OPC_STORE:  legal_o = inst_i.s.funct3 inside {3'b000, 3'b001, 3'b010};
            OPC_OP_IMM: begin
                // Only the shifts constrain the upper bits
                case (inst_i.i.funct3)
                    3'b001:  legal_o = (inst_i.r.funct7 == 7'b0000000);
                    3'b101:  legal_o = inst_i.r.funct7 inside {7'b0000000, 7'b0100000};
                    default: legal_o = 1'b1;
                endcase
            end
            OPC_OP: begin
                legal_o = (inst_i.r.funct7 == 7'b0000000)
                          || (funct10 == {7'b0100000, 3'b000})   // SUB
                          || (funct10 == {7'b0100000, 3'b101});  // SRA
            end
            OPC_FENCE: begin
                // Plain FENCE or FENCE.TSO, rd and rs1 zero
                legal_o = (inst_i.i.funct3 == 3'b000) && (inst_i.i.rd == 5'd0)
                          && (inst_i.i.rs1 == 5'd0)
                          && (inst_i.i.imm[11:8] inside {4'b0000, 4'b1000});
            end
            OPC_SYSTEM: legal_o = inst_i.raw inside {32'h0000_0073, 32'h0010_0073};
            default:    legal_o = 1'b0;
        endcase
    end

endmodule

// ==== verilog/pipe_follower.sv ====
`include "rv_check_macros.svh"

module pipe_follower (
    input  logic             clk,
    input  logic             rst,
    input  logic             advance_i,
    input  logic             flush_i,
    input  logic             fetch_valid_i,
    input  logic [`XLEN-1:0] fetch_inst_i,
    input  logic [`XLEN-1:0] fetch_pc_i,
    input  logic             legal_i,
    retire_if.follower       ret
);
    import rv_check_pkg::*;

    localparam int PD = 0;
    localparam int ID = 1;
    localparam int WB = `NSTAGES - 1;

    slot_t stage_q [`NSTAGES];  // Index 0 is PD, last is WB
    slot_t fetch_slot;

    // Legality is decided once, at fetch, and travels with the word
    always_comb begin
        fetch_slot.inst.raw = fetch_inst_i;
        fetch_slot.pc       = fetch_pc_i;
        fetch_slot.valid    = fetch_valid_i;
        fetch_slot.legal    = legal_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `NSTAGES; s++) begin
                stage_q[s].inst.raw <= `NOP_INST;
                stage_q[s].pc       <= `PC_RESET;
                stage_q[s].valid    <= 1'b0;
                stage_q[s].legal    <= 1'b1;  // NOP is legal
            end
        end else if (advance_i) begin
            stage_q[PD] <= fetch_slot;
            for (int s = 1; s < `NSTAGES; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
            // Flush drops the fetched word and the old PD word,
            // so PD and ID come out of this advance as bubbles
            if (flush_i) begin
                stage_q[PD].valid <= 1'b0;
                stage_q[ID].valid <= 1'b0;
            end
        end
    end

    assign ret.slot   = stage_q[WB];
    assign ret.retire = advance_i && stage_q[WB].valid;  // WB leaves on this advance

endmodule

// ==== verilog/shadow_regfile.sv ====
`include "rv_check_macros.svh"

module shadow_regfile (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_we_i,
    input  logic [`REG_AW-1:0] wb_dst_i,
    input  logic [`XLEN-1:0]  wb_r_i,
    retire_if.regs            ret
);
    logic [`XLEN-1:0] regs_q [`NREGS];

    // Only retiring reports update the copy
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NREGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (ret.retire && wb_we_i && (wb_dst_i != '0)) begin
            regs_q[wb_dst_i] <= wb_r_i;
        end
    end

    // Reads see the state before this retire's write
    assign ret.rs1_val = (ret.slot.inst.r.rs1 == '0) ? '0 : regs_q[ret.slot.inst.r.rs1];
    assign ret.rs2_val = (ret.slot.inst.r.rs2 == '0) ? '0 : regs_q[ret.slot.inst.r.rs2];

endmodule

// ==== verilog/golden_exec.sv ====
`include "rv_check_macros.svh"

module golden_exec (
    input  logic                    clk,
    input  logic                    rst,
    retire_if.exec                  ret,
    input  logic                    wb_we_i,
    input  logic [`REG_AW-1:0]      wb_dst_i,
    input  logic [`XLEN-1:0]        wb_r_i,
    input  logic [`XLEN-1:0]        mem_adr_i,
    input  logic [`XLEN-1:0]        mem_q_i,
    output logic                    err_o,
    output rv_check_pkg::err_code_e err_code_o
);
    import rv_check_pkg::*;

    inst_u            inst;
    logic             is_xori;
    logic             is_auipc;
    logic             is_lb;
    logic             is_blt;
    logic             has_rd_result;  // XORI, AUIPC or LB
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] lb_addr;
    logic [7:0]       lb_byte;
    logic [`XLEN-1:0] gold_val;
    logic             blt_taken;
    logic [`XLEN-1:0] blt_target;
    err_code_e        code_d;

    logic             blt_pend_q;
    logic [`XLEN-1:0] blt_target_q;

    assign inst = ret.slot.inst;

    assign is_xori  = ret.slot.legal && (inst.i.opcode == OPC_OP_IMM) && (inst.i.funct3 == 3'b100);
    assign is_auipc = ret.slot.legal && (inst.u.opcode == OPC_AUIPC);
    assign is_lb    = ret.slot.legal && (inst.i.opcode == OPC_LOAD) && (inst.i.funct3 == 3'b000);
    assign is_blt   = ret.slot.legal && (inst.b.opcode == OPC_BRANCH) && (inst.b.funct3 == 3'b100);
    assign has_rd_result = is_xori || is_auipc || is_lb;

    // Immediates, sign extended as the ISA defines them
    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_u = {inst.u.imm, 12'b0};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};

    assign lb_addr = ret.rs1_val + imm_i;

    always_comb begin
        case (lb_addr[1:0])  // Little endian byte lanes
            2'd0:    lb_byte = mem_q_i[7:0];
            2'd1:    lb_byte = mem_q_i[15:8];
            2'd2:    lb_byte = mem_q_i[23:16];
            default: lb_byte = mem_q_i[31:24];
        endcase
    end

    always_comb begin
        if (is_lb) begin
            gold_val = {{24{lb_byte[7]}}, lb_byte};
        end else if (is_auipc) begin
            gold_val = ret.slot.pc + imm_u;
        end else begin
            gold_val = ret.rs1_val ^ imm_i;
        end
    end

    assign blt_taken  = $signed(ret.rs1_val) < $signed(ret.rs2_val);
    assign blt_target = blt_taken ? (ret.slot.pc + imm_b) : (ret.slot.pc + 32'd4);

    // First failing check wins
    always_comb begin
        code_d = ERR_NONE;
        if (ret.retire) begin
            if (!ret.slot.legal && wb_we_i) begin
                code_d = ERR_ILLEGAL_WE;
            end else if (has_rd_result && ((wb_dst_i != inst.i.rd) ||
                         (!wb_we_i && (inst.i.rd != '0)))) begin
                code_d = ERR_DST;
            end else if (is_lb && (mem_adr_i != lb_addr)) begin
                code_d = ERR_ADDR;
            end else if (has_rd_result && wb_we_i && (wb_r_i != gold_val)) begin
                code_d = ERR_VALUE;
            end else if (blt_pend_q && (ret.slot.pc != blt_target_q)) begin
                code_d = ERR_BRANCH;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            err_o      <= 1'b0;
            err_code_o <= ERR_NONE;
            blt_pend_q <= 1'b0;
        end else begin
            err_o      <= (code_d != ERR_NONE);  // One cycle pulse per failing retire
            err_code_o <= code_d;
            if (ret.retire) begin
                blt_pend_q <= is_blt;  // Any valid retire consumes the pending target
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ret.retire && is_blt) begin
            blt_target_q <= blt_target;
        end
    end

endmodule

// ==== verilog/rv_retire_checker.sv ====
`include "rv_check_macros.svh"

module rv_retire_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance_i,
    input  logic                    flush_i,
    input  logic                    fetch_valid_i,
    input  logic [`XLEN-1:0]        fetch_inst_i,
    input  logic [`XLEN-1:0]        fetch_pc_i,
    input  logic                    wb_we_i,
    input  logic [`REG_AW-1:0]      wb_dst_i,
    input  logic [`XLEN-1:0]        wb_r_i,
    input  logic [`XLEN-1:0]        mem_adr_i,
    input  logic [`XLEN-1:0]        mem_q_i,
    output logic                    err_o,
    output rv_check_pkg::err_code_e err_code_o
);
    logic fetch_legal;  // Legality of the word being fetched

    retire_if ret_if ();

    inst_legality u_legality (
        .inst_i  (fetch_inst_i),
        .legal_o (fetch_legal)
    );

    pipe_follower u_follower (
        .clk           (clk),
        .rst           (rst),
        .advance_i     (advance_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_inst_i  (fetch_inst_i),
        .fetch_pc_i    (fetch_pc_i),
        .legal_i       (fetch_legal),
        .ret           (ret_if.follower)
    );

    shadow_regfile u_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_we_i  (wb_we_i),
        .wb_dst_i (wb_dst_i),
        .wb_r_i   (wb_r_i),
        .ret      (ret_if.regs)
    );

    golden_exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .ret        (ret_if.exec),
        .wb_we_i    (wb_we_i),
        .wb_dst_i   (wb_dst_i),
        .wb_r_i     (wb_r_i),
        .mem_adr_i  (mem_adr_i),
        .mem_q_i    (mem_q_i),
        .err_o      (err_o),
        .err_code_o (err_code_o)
    );

endmodule

// ==== bench/rv_retire_checker_props.sv ====
module rv_retire_checker_props (
    input logic                    clk,
    input logic                    rst,
    input logic                    err_o,
    input rv_check_pkg::err_code_e err_code_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import rv_check_pkg::*;

    // Quiet through reset and the first cycle out of it
    reset_quiet: assert property (@(posedge clk) rst |=> !err_o)
        else $error("err_o high while or right after reset was applied");

    code_matches_flag: assert property (@(posedge clk) disable iff (rst)
        (err_code_o == ERR_NONE) == !err_o)
        else $error("err_code_o disagrees with err_o");

endmodule

bind rv_retire_checker rv_retire_checker_props u_props (
    .clk        (clk),
    .rst        (rst),
    .err_o      (err_o),
    .err_code_o (err_code_o)
);

// ==== bench/tb_rv_retire_checker.sv ====
`include "rv_check_macros.svh"

module tb_rv_retire_checker;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_check_pkg::*;

    localparam int INST_CYCLES  = 7;  // Issue, four shifts, retire, result
    localparam int RESET_CYCLES = 6;
    localparam int XORI_CYCLES  = 4 * INST_CYCLES;
    localparam int AUIPC_CYCLES = 2 * INST_CYCLES;
    localparam int LB_CYCLES    = 13 * INST_CYCLES;
    localparam int BLT_CYCLES   = 10 * INST_CYCLES;
    localparam int ILL_CYCLES   = 2 * INST_CYCLES + 12;  // Flush run adds 12
    localparam int RUN_CYCLES   = RESET_CYCLES + XORI_CYCLES + AUIPC_CYCLES + LB_CYCLES
                                  + BLT_CYCLES + ILL_CYCLES;

    logic             clk = 1'b0;
    logic             rst;
    logic             advance;
    logic             flush;
    logic             fetch_valid;
    logic [`XLEN-1:0] fetch_inst;
    logic [`XLEN-1:0] fetch_pc;
    logic             wb_we;
    logic [4:0]       wb_dst;
    logic [`XLEN-1:0] wb_r;
    logic [`XLEN-1:0] mem_adr;
    logic [`XLEN-1:0] mem_q;
    logic             err;
    err_code_e        err_code;

    rv_retire_checker uut (
        .clk (clk), .rst (rst), .advance_i (advance), .flush_i (flush),
        .fetch_valid_i (fetch_valid), .fetch_inst_i (fetch_inst), .fetch_pc_i (fetch_pc),
        .wb_we_i (wb_we), .wb_dst_i (wb_dst), .wb_r_i (wb_r),
        .mem_adr_i (mem_adr), .mem_q_i (mem_q), .err_o (err), .err_code_o (err_code)
    );

    always #50 clk = ~clk;  // 100 ns period

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] sext13(input logic [12:0] v);
        return {{19{v[12]}}, v};
    endfunction

    function automatic logic [7:0] lane_byte(input logic [31:0] w, input int lane);
        logic [31:0] shifted;
        shifted = w >> (8 * lane);
        return shifted[7:0];
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Branch encoding scatters the immediate bits
    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic clear_report();
        wb_we   = 1'b0;
        wb_dst  = '0;
        wb_r    = '0;
        mem_adr = '0;
        mem_q   = '0;
    endtask

    task automatic drive_advance(input logic valid, input logic [31:0] inst,
                                 input logic [31:0] pc, input logic flush_v);
        @(negedge clk);
        advance     = 1'b1;
        flush       = flush_v;
        fetch_valid = valid;
        fetch_inst  = inst;
        fetch_pc    = pc;
        clear_report();
    endtask

    task automatic issue(input logic [31:0] inst, input logic [31:0] pc);
        drive_advance(1'b1, inst, pc, 1'b0);
    endtask

    // Report for the WB slot, then one idle cycle so the result is registered
    task automatic retire(input logic we, input logic [4:0] dst, input logic [31:0] r,
                          input logic [31:0] adr, input logic [31:0] q);
        @(negedge clk);
        advance     = 1'b1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_inst  = `NOP_INST;
        wb_we       = we;
        wb_dst      = dst;
        wb_r        = r;
        mem_adr     = adr;
        mem_q       = q;
        @(negedge clk);
        advance = 1'b0;
        clear_report();
    endtask

    task automatic expect_err(input string name, input err_code_e code);
        check(name, 32'(code != ERR_NONE), 32'(err));
        check(name, 32'(code), 32'(err_code));
    endtask

    task automatic run_inst(input string name, input logic [31:0] inst, input logic [31:0] pc,
                            input logic we, input logic [4:0] dst, input logic [31:0] r,
                            input logic [31:0] adr, input logic [31:0] q,
                            input err_code_e code);
        issue(inst, pc);
        repeat (4) drive_advance(1'b0, `NOP_INST, 32'd0, 1'b0);
        retire(we, dst, r, adr, q);  // Sixth advance
        expect_err(name, code);
    endtask

    // ADDI rd, x0, 0 reported with an arbitrary value fills the shadow copy
    task automatic seed_reg(input string name, input logic [4:0] rd, input logic [31:0] val);
        run_inst(name, enc_i(12'h000, 5'd0, 3'b000, rd, OPC_OP_IMM), 32'h0000_0100,
                 1'b1, rd, val, 32'd0, 32'd0, ERR_NONE);
        check(name, val, uut.u_regs.regs_q[rd]);
    endtask

    task automatic test_xori();
        logic [31:0] a;
        logic [31:0] rnd;
        logic [31:0] inst;
        logic [31:0] exp;
        a    = $urandom();
        rnd  = $urandom();
        exp  = a ^ sext12(rnd[11:0]);
        inst = enc_i(rnd[11:0], 5'd5, 3'b100, 5'd6, OPC_OP_IMM);
        seed_reg("xori_seed", 5'd5, a);
        run_inst("xori_ok", inst, 32'h300, 1'b1, 5'd6, exp, 32'd0, 32'd0, ERR_NONE);
        run_inst("xori_bad_value", inst, 32'h300, 1'b1, 5'd6, exp ^ 32'h1, 32'd0, 32'd0,
                 ERR_VALUE);
        run_inst("xori_bad_dst", inst, 32'h300, 1'b1, 5'd7, exp, 32'd0, 32'd0, ERR_DST);
    endtask

    task automatic test_auipc();
        logic [31:0] rnd;
        logic [31:0] inst;
        logic [31:0] exp;
        rnd  = $urandom();
        inst = {rnd[31:12], 5'd8, OPC_AUIPC};
        exp  = 32'h0000_0400 + {rnd[31:12], 12'h000};
        run_inst("auipc_ok", inst, 32'h400, 1'b1, 5'd8, exp, 32'd0, 32'd0, ERR_NONE);
        run_inst("auipc_bad_value", inst, 32'h400, 1'b1, 5'd8, exp + 32'h4, 32'd0, 32'd0,
                 ERR_VALUE);
    endtask

    task automatic test_lb();
        logic [31:0] base;
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [31:0] q;
        logic [31:0] q_neg;
        logic [31:0] adr;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [7:0]  b_any;
        logic [7:0]  b_neg;
        rnd  = $urandom();
        base = {rnd[31:2], 2'b00};  // Aligned, so the offset comes from imm
        seed_reg("lb_seed", 5'd9, base);
        for (int off = 0; off < 4; off++) begin
            rnd   = $urandom();
            imm   = {rnd[11:2], 2'(off)};
            q     = $urandom();
            q_neg = q | (32'h80 << (8 * off));  // Selected byte negative
            b_any = lane_byte(q, off);
            b_neg = lane_byte(q_neg, off);
            adr   = base + sext12(imm);
            pc    = 32'h0000_0600 + 32'(4 * off);
            inst  = enc_i(imm, 5'd9, 3'b000, 5'd10, OPC_LOAD);
            run_inst("lb_ok", inst, pc, 1'b1, 5'd10, {{24{b_any[7]}}, b_any}, adr, q,
                     ERR_NONE);
            run_inst("lb_bad_addr", inst, pc, 1'b1, 5'd10, {{24{b_any[7]}}, b_any},
                     adr + 32'h4, q, ERR_ADDR);
            run_inst("lb_zero_ext", inst, pc, 1'b1, 5'd10, {24'h0, b_neg}, adr, q_neg,
                     ERR_VALUE);
        end
    endtask

    task automatic test_blt();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        logic [12:0] imm;
        logic [31:0] pc;
        logic [31:0] taken;
        logic [31:0] blt_t;
        logic [31:0] blt_n;
        a     = $urandom() | 32'h8000_0000;  // Negative
        b     = $urandom() & 32'h7fff_ffff;  // Non-negative
        rnd   = $urandom();
        imm   = {rnd[12:2], 2'b00};
        pc    = 32'h0000_0800;
        taken = pc + sext13(imm);
        blt_t = enc_b(imm, 5'd12, 5'd11, 3'b100);  // x11 < x12
        blt_n = enc_b(imm, 5'd11, 5'd12, 3'b100);  // x12 < x11 is false
        seed_reg("blt_seed_a", 5'd11, a);
        seed_reg("blt_seed_b", 5'd12, b);
        run_inst("blt_taken", blt_t, pc, 1'b0, 5'd0, 32'd0, 32'd0, 32'd0, ERR_NONE);
        run_inst("blt_taken_next", `NOP_INST, taken, 1'b0, 5'd0, 32'd0, 32'd0, 32'd0,
                 ERR_NONE);
        run_inst("blt_taken", blt_t, pc, 1'b0, 5'd0, 32'd0, 32'd0, 32'd0, ERR_NONE);
        run_inst("blt_taken_wrong_pc", `NOP_INST, taken + 32'd8, 1'b0, 5'd0, 32'd0, 32'd0,
                 32'd0, ERR_BRANCH);
        run_inst("blt_not_taken", blt_n, pc, 1'b0, 5'd0, 32'd0, 32'd0, 32'd0, ERR_NONE);
        run_inst("blt_not_taken_next", `NOP_INST, pc + 32'd4, 1'b0, 5'd0, 32'd0, 32'd0,
                 32'd0, ERR_NONE);
        run_inst("blt_not_taken", blt_n, pc, 1'b0, 5'd0, 32'd0, 32'd0, 32'd0, ERR_NONE);
        run_inst("blt_not_taken_wrong_pc", `NOP_INST, pc + 32'd8, 1'b0, 5'd0, 32'd0, 32'd0,
                 32'd0, ERR_BRANCH);
    endtask

    task automatic test_illegal_flush();
        logic [31:0] rnd;
        logic [31:0] ill;
        rnd = $urandom();
        ill = {rnd[31:7], 7'b1111111};  // Opcode outside RV32I
        run_inst("illegal_we", ill, 32'h900, 1'b1, 5'd3, rnd, 32'd0, 32'd0, ERR_ILLEGAL_WE);
        run_inst("illegal_no_we", ill, 32'h900, 1'b0, 5'd0, 32'd0, 32'd0, 32'd0, ERR_NONE);
        // Flush catches one word in ID and one in PD
        issue(enc_i(12'h0ff, 5'd5, 3'b100, 5'd6, OPC_OP_IMM), 32'h0000_0a00);
        drive_advance(1'b1, enc_i(12'h001, 5'd5, 3'b100, 5'd6, OPC_OP_IMM), 32'h0000_0a04,
                      1'b1);
        for (int n = 0; n < 5; n++) begin
            retire(1'b1, 5'd31, 32'hdead_beef, 32'd0, 32'd0);
            expect_err("flush_bubble", ERR_NONE);
        end
    endtask

    initial begin
        void'($urandom(32'h6f2e_6d07));
        rst         = 1'b1;
        advance     = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_inst  = `NOP_INST;
        fetch_pc    = '0;
        clear_report();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        expect_err("reset", ERR_NONE);
        test_xori();
        test_auipc();
        test_lb();
        test_blt();
        test_illegal_flush();
        $display("*** TEST PASSED ***");
        $finish;
    end

    // 1.5 times the expected run length at 100 ns per cycle
    initial begin
        #(RUN_CYCLES * 150);
        $display("Timeout: the tests did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/rv_check_pkg.sv
verilog/retire_if.sv
verilog/inst_legality.sv
verilog/pipe_follower.sv
verilog/shadow_regfile.sv
verilog/golden_exec.sv
verilog/rv_retire_checker.sv
bench/rv_retire_checker_props.sv
bench/tb_rv_retire_checker.sv

// ==== run.sh ====
#!/bin/sh
# Build the retirement checker testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_retire_checker -Mdir obj_dir -f all.f

./obj_dir/Vtb_rv_retire_checker | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    exit 0
fi
exit 1
